//--- sim.f
+incdir+tb
design/pce_core_pkg.sv
design/bridge_settings_regs.sv
design/snac_player_router.sv
design/analog_video_prep.sv
design/pce_core_top.sv
tb/tb_pce_core_top.sv

//--- Bender.yml
package:
  name: pce_core_glue

sources:
  - files:
      - design/pce_core_pkg.sv
      - design/bridge_settings_regs.sv
      - design/snac_player_router.sv
      - design/analog_video_prep.sv
      - design/pce_core_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_pce_core_top.sv

//--- tb/tb_pce_core_tasks.svh
//////////////////////////////
// directed tests and their checks
// bus access, routing reference, pixel stepping
//////////////////////////////

`ifndef TB_PCE_CORE_TASKS_SVH
`define TB_PCE_CORE_TASKS_SVH

// carrier increments for the two standards
localparam logic [39:0] ntsc_inc = 40'd91625968981;
localparam logic [39:0] pal_inc  = 40'd114532461227;

pce_core_pkg::analog_out_t expected_analog;
logic                      last_ce_pix;

task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
  assert (got === exp) else begin
    error_count++;
    $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
    $display("Test FAILED");
    $fatal(1, "stopped at first mismatch");
  end
endtask

task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
  @(negedge clk_74a);
  bridge_addr    = addr;
  bridge_wr_data = data;
  bridge_wr      = 1'b1;
  @(negedge clk_74a);
  bridge_wr      = 1'b0;
  bridge_addr    = '0;
  bridge_wr_data = '0;
endtask

task automatic bus_read_expect(input logic [31:0] addr, input logic [31:0] exp);
  @(negedge clk_74a);
  bridge_addr = addr;
  bridge_rd   = 1'b1;
  #1;
  expect_eq("bridge_rd_data", bridge_rd_data, exp);
  bridge_rd   = 1'b0;
  bridge_addr = '0;
endtask

// video type 13:10, assignment 9:6, spare 5, controller type 4:0
function automatic logic [31:0] settings_word(input logic [3:0] vt, input logic [3:0] code,
                                              input logic [4:0] ct);
  return {18'd0, vt, code, 1'b0, ct};
endfunction

task automatic draw_keys(output pce_core_pkg::player_keys_t keys);
  logic [31:0] r;
  for (int i = 0; i < 4; i++) begin
    r       = $random(seed);
    keys[i] = r[15:0];
  end
endtask

// adapter port feeding each player or -1 for the handheld pad
function automatic int route_source(input logic [3:0] code, input int player);
  int src[4];
  case (code)
    4'd0:    src = '{0, -1, -1, -1};
    4'd1:    src = '{-1, 0, -1, -1};
    4'd2:    src = '{0, 1, -1, -1};
    4'd3:    src = '{1, 0, -1, -1};
    4'd4:    src = '{0, 1, 2, 3};
    4'd5:    src = '{3, 2, 1, 0};
    4'd6:    src = '{-1, -1, 0, 1};
    default: src = '{-1, -1, -1, -1};
  endcase
  return src[player];
endfunction

task automatic register_readback();
  logic [31:0] word;
  word = 32'hFFFF_2C47;
  bus_read_expect(pce_core_pkg::addr_analog_settings, 32'h0);
  expect_eq("core_reset", core_reset, 0);
  expect_eq("player_keys", player_keys, 0);
  expect_eq("yc_config.chroma_add", yc_config.chroma_add, 0);
  expect_eq("yc_config.chroma_mult", yc_config.chroma_mult, 0);
  bus_write(pce_core_pkg::addr_analog_settings, word);
  // upper bits of the bus word are dropped
  bus_read_expect(pce_core_pkg::addr_analog_settings, {18'd0, word[13:0]});
  bus_read_expect(32'h1234_5678, 32'h0);
  bus_read_expect(pce_core_pkg::addr_chroma_add, 32'h0);
endtask

task automatic core_reset_hold();
  @(negedge clk_74a);
  expect_eq("core_reset", core_reset, 0);
  bridge_addr = pce_core_pkg::addr_core_reset;
  bridge_wr   = 1'b1;
  for (int i = 0; i < hold_cycles; i++) begin
    @(negedge clk_74a);
    bridge_wr   = 1'b0;
    bridge_addr = '0;
    expect_eq("core_reset", core_reset, 1);
  end
  repeat (4) begin
    @(negedge clk_74a);
    expect_eq("core_reset", core_reset, 0);
  end
endtask

task automatic player_routing();
  pce_core_pkg::player_keys_t pk;
  pce_core_pkg::player_keys_t sk;
  pce_core_pkg::player_keys_t exp_keys;
  logic [3:0]                 codes[8];
  int                         src;
  codes = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd9};
  // adapter off so every player stays on the handheld
  bus_write(pce_core_pkg::addr_analog_settings, settings_word(4'd0, 4'd4, 5'd0));
  draw_keys(pk);
  draw_keys(sk);
  @(negedge clk_74a);
  pocket_keys = pk;
  snac_keys   = sk;
  @(posedge clk_74a);
  #1;
  expect_eq("player_keys", player_keys, pk);
  foreach (codes[c]) begin
    bus_write(pce_core_pkg::addr_analog_settings, settings_word(4'd0, codes[c], 5'd3));
    repeat (3) begin
      draw_keys(pk);
      draw_keys(sk);
      @(negedge clk_74a);
      pocket_keys = pk;
      snac_keys   = sk;
      for (int p = 0; p < 4; p++) begin
        src         = route_source(codes[c], p);
        exp_keys[p] = (src < 0) ? pk[p] : sk[src];
      end
      @(posedge clk_74a);
      #1;
      expect_eq("player_keys", player_keys, exp_keys);
    end
  end
endtask

task automatic yc_decode();
  logic [3:0] types[5];
  logic [3:0] vt;
  logic       exp_yc;
  logic       exp_pal;
  types = '{4'd0, 4'd3, 4'd4, 4'd11, 4'd12};
  bus_write(pce_core_pkg::addr_chroma_add, 32'd19);
  bus_write(pce_core_pkg::addr_chroma_mult, 32'd7);
  foreach (types[t]) begin
    vt      = types[t];
    exp_yc  = (vt == 4'd3) || (vt == 4'd4) || (vt == 4'd11) || (vt == 4'd12);
    exp_pal = (vt == 4'd4) || (vt == 4'd12);
    bus_write(pce_core_pkg::addr_analog_settings, settings_word(vt, 4'd0, 5'd0));
    #1;
    expect_eq("yc_config.yc_en", yc_config.yc_en, exp_yc);
    expect_eq("yc_config.pal", yc_config.pal, exp_pal);
    expect_eq("yc_config.phase_inc", yc_config.phase_inc, exp_pal ? pal_inc : ntsc_inc);
    expect_eq("yc_config.chroma_add", yc_config.chroma_add, 19);
    expect_eq("yc_config.chroma_mult", yc_config.chroma_mult, 7);
  end
endtask

// one clock of video input checked against the capture rule
task automatic pixel_step(input logic [23:0] rgb, input logic hs, input logic vs,
                          input logic hb, input logic vb, input logic ce);
  @(negedge clk_74a);
  video_in.rgb    = rgb;
  video_in.hsync  = hs;
  video_in.vsync  = vs;
  video_in.hblank = hb;
  video_in.vblank = vb;
  video_in.ce_pix = ce;
  if (ce && !last_ce_pix) begin
    expected_analog.rgb     = rgb;
    expected_analog.csync   = (hs == vs);
    expected_analog.blank_n = !(hb || vb);
  end
  last_ce_pix = ce;
  @(posedge clk_74a);
  #1;
  expect_eq("analog_out", analog_out, expected_analog);
endtask

task automatic blank_and_capture();
  bus_write(pce_core_pkg::addr_analog_settings, settings_word(4'd11, 4'd0, 5'd0));
  video_in.rgb = 24'h12_3456;
  #1;
  expect_eq("pocket_rgb", pocket_rgb, 0);
  bus_write(pce_core_pkg::addr_analog_settings, settings_word(4'd3, 4'd0, 5'd0));
  #1;
  expect_eq("pocket_rgb", pocket_rgb, 24'h12_3456);
  // ce_pix has been low since reset
  expected_analog = '0;
  last_ce_pix     = 1'b0;
  pixel_step(24'h12_3456, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
  pixel_step(24'h12_3456, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
  pixel_step(24'hAB_CDEF, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1);
  pixel_step(24'h0F_1E2D, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
  pixel_step(24'h0F_1E2D, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1);
  pixel_step(24'h5A_5A5A, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
  pixel_step(24'h5A_5A5A, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
  pixel_step(24'hC3_3C99, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
  pixel_step(24'h96_0F3C, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
  pixel_step(24'h96_0F3C, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
endtask

`endif

//--- tb/tb_pce_core_top.sv
//////////////////////////////
// testbench top for the settings and output glue
// clock, reset, dut, watchdog and test order
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_pce_core_top;

  localparam int hold_cycles     = 16;
  localparam int watchdog_cycles = 2000;

  logic                       clk_74a;
  logic                       pll_core_locked;
  logic [31:0]                bridge_addr;
  logic                       bridge_wr;
  logic [31:0]                bridge_wr_data;
  logic                       bridge_rd;
  logic [31:0]                bridge_rd_data;
  pce_core_pkg::player_keys_t pocket_keys;
  pce_core_pkg::player_keys_t snac_keys;
  pce_core_pkg::video_in_t    video_in;
  logic                       core_reset;
  pce_core_pkg::player_keys_t player_keys;
  logic [23:0]                pocket_rgb;
  pce_core_pkg::analog_out_t  analog_out;
  pce_core_pkg::yc_config_t   yc_config;

  integer seed;
  int     error_count;

  `include "tb_pce_core_tasks.svh"

  pce_core_top #(
    .reset_hold_cycles(32'd16)
  ) i_dut (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd      (bridge_rd),
    .bridge_rd_data (bridge_rd_data),
    .pocket_keys    (pocket_keys),
    .snac_keys      (snac_keys),
    .video_in       (video_in),
    .core_reset     (core_reset),
    .player_keys    (player_keys),
    .pocket_rgb     (pocket_rgb),
    .analog_out     (analog_out),
    .yc_config      (yc_config)
  );

  ////////////////////////////// clock
  initial begin
    clk_74a = 1'b0;
    forever #2 clk_74a = ~clk_74a;
  end

  ////////////////////////////// test order
  initial begin
    seed            = 5;
    error_count     = 0;
    pll_core_locked = 1'b0;
    bridge_addr     = '0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = '0;
    bridge_rd       = 1'b0;
    pocket_keys     = '0;
    snac_keys       = '0;
    video_in        = '0;

    // four clocks in reset
    repeat (4) @(negedge clk_74a);
    pll_core_locked = 1'b1;

    register_readback();
    core_reset_hold();
    player_routing();
    yc_decode();
    blank_and_capture();

    repeat (2) @(negedge clk_74a);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog, far longer than the whole sequence
  initial begin
    repeat (watchdog_cycles) @(posedge clk_74a);
    $display("watchdog expired before the tests finished");
    $display("Test FAILED");
    $fatal(1, "run stopped by watchdog");
  end

endmodule

`default_nettype wire

//--- design/pce_core_top.sv
//////////////////////////////
// settings and output glue top level
// bridge registers, player router, video preparation
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pce_core_top #(
  parameter logic [31:0] reset_hold_cycles = 32'h0010_0000
) (
  input  wire logic                      clk_74a,
  input  wire logic                      pll_core_locked,

  // host bridge
  input  wire logic [31:0]               bridge_addr,
  input  wire logic                      bridge_wr,
  input  wire logic [31:0]               bridge_wr_data,
  input  wire logic                      bridge_rd,
  output      logic [31:0]               bridge_rd_data,

  input  wire pce_core_pkg::player_keys_t pocket_keys,
  input  wire pce_core_pkg::player_keys_t snac_keys,
  input  wire pce_core_pkg::video_in_t    video_in,

  output      logic                      core_reset,
  output      pce_core_pkg::player_keys_t player_keys,
  output      logic [23:0]               pocket_rgb,
  output      pce_core_pkg::analog_out_t  analog_out,
  output      pce_core_pkg::yc_config_t   yc_config
);

  pce_core_pkg::analog_settings_t settings;
  pce_core_pkg::chroma_t          chroma_add;
  pce_core_pkg::chroma_t          chroma_mult;

  bridge_settings_regs #(
    .reset_hold_cycles(reset_hold_cycles)
  ) i_settings (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd      (bridge_rd),
    .bridge_rd_data (bridge_rd_data),
    .settings       (settings),
    .chroma_add     (chroma_add),
    .chroma_mult    (chroma_mult),
    .core_reset     (core_reset)
  );

  snac_player_router i_router (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .settings       (settings),
    .pocket_keys    (pocket_keys),
    .snac_keys      (snac_keys),
    .player_keys    (player_keys)
  );

  analog_video_prep i_video (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .settings       (settings),
    .chroma_add     (chroma_add),
    .chroma_mult    (chroma_mult),
    .video_in       (video_in),
    .pocket_rgb     (pocket_rgb),
    .analog_out     (analog_out),
    .yc_config      (yc_config)
  );

endmodule

`default_nettype wire

//--- design/analog_video_prep.sv
//////////////////////////////
// analog video preparation
// video type decode, y/c config, screen blanking
// and pixel edge capture
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module analog_video_prep (
  input  wire logic                          clk_74a,
  input  wire logic                          pll_core_locked,

  input  wire pce_core_pkg::analog_settings_t settings,
  input  wire pce_core_pkg::chroma_t          chroma_add,
  input  wire pce_core_pkg::chroma_t          chroma_mult,
  input  wire pce_core_pkg::video_in_t        video_in,

  output      logic [23:0]                   pocket_rgb,
  output      pce_core_pkg::analog_out_t      analog_out,
  output      pce_core_pkg::yc_config_t       yc_config
);

  logic is_pal;
  logic is_yc;
  logic ce_pix_r;
  logic ce_pix_rise;
  logic csync;
  logic blank_n;

  ////////////////////////////// video type decode
  always_comb begin
    is_yc  = 1'b0;
    is_pal = 1'b0;
    case (settings.video_type)
      pce_core_pkg::video_yc_ntsc,
      pce_core_pkg::video_yc_ntsc_blank: begin
        is_yc = 1'b1;
      end
      pce_core_pkg::video_yc_pal,
      pce_core_pkg::video_yc_pal_blank: begin
        is_yc  = 1'b1;
        is_pal = 1'b1;
      end
      // rgbs and anything else stay plain rgb
      default: begin
        is_yc  = 1'b0;
        is_pal = 1'b0;
      end
    endcase
  end

  always_comb begin
    yc_config.yc_en       = is_yc;
    yc_config.pal         = is_pal;
    yc_config.phase_inc   = is_pal ? pce_core_pkg::pal_phase_inc
                                   : pce_core_pkg::ntsc_phase_inc;
    yc_config.chroma_add  = chroma_add;
    yc_config.chroma_mult = chroma_mult;
  end

  // dark handheld screen while the analog output is in use
  assign pocket_rgb = settings.video_type[3] ? 24'h00_0000 : video_in.rgb;

  ////////////////////////////// sync and capture
  // composite sync as xnor of the two syncs
  assign csync       = (video_in.hsync == video_in.vsync);
  assign blank_n     = ~(video_in.hblank | video_in.vblank);
  assign ce_pix_rise = video_in.ce_pix && !ce_pix_r;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      ce_pix_r   <= 1'b0;
      analog_out <= '0;
    end else begin
      ce_pix_r <= video_in.ce_pix;
      if (ce_pix_rise) begin
        analog_out.rgb     <= video_in.rgb;
        analog_out.csync   <= csync;
        analog_out.blank_n <= blank_n;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/snac_player_router.sv
//////////////////////////////
// player routing
// adapter or handheld controllers onto four player slots
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module snac_player_router (
  input  wire logic                          clk_74a,
  input  wire logic                          pll_core_locked,

  input  wire pce_core_pkg::analog_settings_t settings,
  input  wire pce_core_pkg::player_keys_t     pocket_keys,
  input  wire pce_core_pkg::player_keys_t     snac_keys,
  output      pce_core_pkg::player_keys_t     player_keys
);

  pce_core_pkg::player_keys_t keys_next;

  // players not named in a code keep their own handheld controller
  always_comb begin
    keys_next = pocket_keys;
    if (settings.cont_type != 5'd0) begin
      case (settings.cont_assignment)
        pce_core_pkg::assign_p1: begin
          keys_next[0] = snac_keys[0];
        end
        pce_core_pkg::assign_p1_as_p2: begin
          keys_next[1] = snac_keys[0];
        end
        pce_core_pkg::assign_p1_p2: begin
          keys_next[0] = snac_keys[0];
          keys_next[1] = snac_keys[1];
        end
        pce_core_pkg::assign_swap_p1_p2: begin
          keys_next[0] = snac_keys[1];
          keys_next[1] = snac_keys[0];
        end
        // multitap, all four from the adapter
        pce_core_pkg::assign_all_four: begin
          keys_next = snac_keys;
        end
        pce_core_pkg::assign_reversed: begin
          keys_next[0] = snac_keys[3];
          keys_next[1] = snac_keys[2];
          keys_next[2] = snac_keys[1];
          keys_next[3] = snac_keys[0];
        end
        pce_core_pkg::assign_p3_p4: begin
          keys_next[2] = snac_keys[0];
          keys_next[3] = snac_keys[1];
        end
        // unknown codes fall back to all handheld
        default: begin
          keys_next = pocket_keys;
        end
      endcase
    end
  end

  ////////////////////////////// output stage
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      player_keys <= '0;
    end else begin
      player_keys <= keys_next;
    end
  end

endmodule

`default_nettype wire

//--- design/bridge_settings_regs.sv
//////////////////////////////
// bridge settings registers
// write decode, readback mux and core reset hold counter
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bridge_settings_regs #(
  parameter logic [31:0] reset_hold_cycles = 32'h0010_0000
) (
  input  wire logic                          clk_74a,
  input  wire logic                          pll_core_locked,

  input  wire logic [31:0]                   bridge_addr,
  input  wire logic                          bridge_wr,
  input  wire logic [31:0]                   bridge_wr_data,
  input  wire logic                          bridge_rd,
  output      logic [31:0]                   bridge_rd_data,

  output      pce_core_pkg::analog_settings_t settings,
  output      pce_core_pkg::chroma_t          chroma_add,
  output      pce_core_pkg::chroma_t          chroma_mult,
  output      logic                          core_reset
);

  logic [31:0] reset_cnt;

  logic wr_settings;
  logic wr_chroma_add;
  logic wr_chroma_mult;
  logic wr_core_reset;

  ////////////////////////////// write decode
  always_comb begin
    wr_settings    = bridge_wr && (bridge_addr == pce_core_pkg::addr_analog_settings);
    wr_chroma_add  = bridge_wr && (bridge_addr == pce_core_pkg::addr_chroma_add);
    wr_chroma_mult = bridge_wr && (bridge_addr == pce_core_pkg::addr_chroma_mult);
    wr_core_reset  = bridge_wr && (bridge_addr == pce_core_pkg::addr_core_reset);
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings    <= '0;
      chroma_add  <= '0;
      chroma_mult <= '0;
    end else begin
      if (wr_settings) begin
        settings <= pce_core_pkg::analog_settings_t'(bridge_wr_data[13:0]);
      end
      // chroma fine tune, 0 to 31
      if (wr_chroma_add) begin
        chroma_add <= bridge_wr_data[4:0];
      end
      if (wr_chroma_mult) begin
        chroma_mult <= bridge_wr_data[4:0];
      end
    end
  end

  ////////////////////////////// core reset hold
  // a new command restarts the hold from the top
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_cnt <= '0;
    end else if (wr_core_reset) begin
      reset_cnt <= reset_hold_cycles;
    end else if (reset_cnt != '0) begin
      reset_cnt <= reset_cnt - 32'd1;
    end
  end

  // high for exactly reset_hold_cycles after the command edge
  assign core_reset = (reset_cnt != '0);

  ////////////////////////////// readback
  // only the settings word is readable, during a read strobe
  always_comb begin
    bridge_rd_data = '0;
    if (bridge_rd && (bridge_addr == pce_core_pkg::addr_analog_settings)) begin
      bridge_rd_data = {18'h0, settings};
    end
  end

endmodule

`default_nettype wire

//--- design/pce_core_pkg.sv
//////////////////////////////
// shared types for the settings and output glue
// bridge addresses, controller words, analog settings,
// y/c configuration, video structs and carrier constants
//////////////////////////////

`default_nettype none

package pce_core_pkg;

  ////////////////////////////// bridge map
  localparam logic [31:0] addr_core_reset      = 32'h0000_0050;
  localparam logic [31:0] addr_chroma_add      = 32'h0000_0400;
  localparam logic [31:0] addr_chroma_mult     = 32'h0000_0410;
  localparam logic [31:0] addr_analog_settings = 32'hF700_0000;

  // up, down, left, right in [3:0], buttons 1-6 in [9:4], select 14, start 15
  typedef logic [15:0] keys_t;

  // index 0 is player 1
  typedef keys_t [3:0] player_keys_t;

  typedef enum logic [3:0] {
    assign_p1         = 4'd0,
    assign_p1_as_p2   = 4'd1,
    assign_p1_p2      = 4'd2,
    assign_swap_p1_p2 = 4'd3,
    assign_all_four   = 4'd4,
    assign_reversed   = 4'd5,
    assign_p3_p4      = 4'd6
  } snac_assign_e;

  // bit 3 set means the handheld screen goes dark
  typedef enum logic [3:0] {
    video_rgbs          = 4'd0,
    video_yc_ntsc       = 4'd3,
    video_yc_pal        = 4'd4,
    video_yc_ntsc_blank = 4'd11,
    video_yc_pal_blank  = 4'd12
  } analog_video_e;

  // same layout as the 14-bit bridge word
  typedef struct packed {
    logic [3:0] video_type;
    logic [3:0] cont_assignment;
    logic       spare;
    logic [4:0] cont_type;
  } analog_settings_t;

  typedef logic [4:0] chroma_t;

  typedef struct packed {
    logic        yc_en;
    logic        pal;
    logic [39:0] phase_inc;
    chroma_t     chroma_add;
    chroma_t     chroma_mult;
  } yc_config_t;

  typedef struct packed {
    logic [23:0] rgb;
    logic        hsync;
    logic        vsync;
    logic        hblank;
    logic        vblank;
    logic        ce_pix;
  } video_in_t;

  typedef struct packed {
    logic [23:0] rgb;
    logic        csync;
    logic        blank_n;
  } analog_out_t;

  ////////////////////////////// colour carrier
  // subcarrier over video clock, scaled by 2^40
  localparam logic [39:0] ntsc_phase_inc = 40'd91625968981;
  localparam logic [39:0] pal_phase_inc  = 40'd114532461227;

endpackage

`default_nettype wire
